// File: command_translator/command_translator.sv
module command_translator (
    input  logic                  clk,
    input  logic                  rst,
    input  drive_pkg::drive_cmd_e command,
    input  logic                  valid,
    input  logic                  uart_ready,
    output logic [7:0]            ascii_out,
    output logic                  cmd_ready
);
    import drive_pkg::*;

    drive_cmd_e            cmd_q;    // Command of the line in flight
    logic [JSON_IDX_W-1:0] idx;      // Byte currently offered to the UART
    logic [7:0]            t_char;
    logic [39:0]           l_field;  // Five ASCII characters
    logic [39:0]           r_field;
    logic [8*JSON_LEN-1:0] line_bits;
    logic [7:0]            line [JSON_LEN];
    logic                  start_line;

    // New line only when nothing is pending on ascii_out
    assign start_line = valid && !cmd_ready;

    // Per-command fields of the line
    always_comb begin
        case (cmd_q)
            FAST_LEFT: begin
                t_char  = "1";
                l_field = "-0.50";
                r_field = "00.50";
            end
            LEFT: begin
                t_char  = "1";
                l_field = "-0.25";
                r_field = "00.25";
            end
            STRAIGHT: begin
                t_char  = "1";
                l_field = "00.50";
                r_field = "00.50";
            end
            RIGHT: begin
                t_char  = "1";
                l_field = "00.25";
                r_field = "-0.25";
            end
            HARD_RIGHT: begin
                t_char  = "1";
                l_field = "00.50";
                r_field = "-0.50";
            end
            default: begin  // STOP and the unnamed codes
                t_char  = "0";
                l_field = "00.00";
                r_field = "00.00";
            end
        endcase
    end

    // {"T":t,"L":lllll,"R":rrrrr} plus newline, first byte in the top bits
    assign line_bits = {"{\"T\":", t_char,
                        ",\"L\":", l_field,
                        ",\"R\":", r_field,
                        "}", 8'h0a};

    // Split into bytes, byte 0 at index 0
    always_comb begin
        for (int i = 0; i < JSON_LEN; i++) begin
            line[i] = line_bits[8*(JSON_LEN-1-i) +: 8];
        end
    end

    // Zero when no line is in progress
    assign ascii_out = cmd_ready ? line[idx] : 8'h00;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_ready <= 1'b0;
            idx       <= '0;
        end else if (start_line) begin
            cmd_ready <= 1'b1;
            idx       <= '0;
        end else if (cmd_ready && uart_ready) begin
            if (idx == JSON_LAST) begin
                cmd_ready <= 1'b0;  // Newline taken, line done
                idx       <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    // Command stays frozen for the whole line
    always_ff @(posedge clk) begin
        if (start_line) begin
            cmd_q <= command;
        end
    end

endmodule

// File: common/drive_pkg.sv
package drive_pkg;

    // Drive commands as they arrive from the controller
    // Codes 6 and 7 have no name and fall back to STOP
    typedef enum logic [2:0] {
        STOP       = 3'd0,
        FAST_LEFT  = 3'd1,
        LEFT       = 3'd2,
        STRAIGHT   = 3'd3,
        RIGHT      = 3'd4,
        HARD_RIGHT = 3'd5
    } drive_cmd_e;

    // Bytes per JSON line, closing newline included
    localparam int JSON_LEN = 28;

    // Byte index into the line
    localparam int JSON_IDX_W = $clog2(JSON_LEN);

    // Index of the newline, the last byte sent
    localparam logic [JSON_IDX_W-1:0] JSON_LAST = JSON_IDX_W'(JSON_LEN - 1);

endpackage

// File: common/uart_pkg.sv
package uart_pkg;

    localparam int CLKS_PER_BIT = 4;  // Fixed bit period in clocks
    localparam int FRAME_BITS   = 10; // Start, 8 data, stop
    localparam int DATA_BITS    = FRAME_BITS - 2;

    // Counter widths and terminal counts
    localparam int CLK_CNT_W = $clog2(CLKS_PER_BIT);
    localparam int BIT_CNT_W = $clog2(DATA_BITS);
    localparam logic [CLK_CNT_W-1:0] LAST_CLK = CLK_CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [BIT_CNT_W-1:0] LAST_BIT = BIT_CNT_W'(DATA_BITS - 1);

    // Transmitter states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        START = 2'd1,
        DATA  = 2'd2,
        STOP  = 2'd3
    } uart_state_e;

endpackage

// File: project.f
common/drive_pkg.sv
common/uart_pkg.sv
rtl/command_hold.sv
command_translator/command_translator.sv
uart_tx/uart_tx.sv
rtl/drive_link_top.sv
tb/drive_link_checker.sv
tb/drive_link_tb.sv

// File: rtl/command_hold.sv
module command_hold (
    input  logic                  clk,
    input  logic                  rst,
    input  drive_pkg::drive_cmd_e command,
    input  logic                  valid,
    input  logic                  cmd_ready,
    output drive_pkg::drive_cmd_e pend_cmd,
    output logic                  pend_valid
);
    import drive_pkg::*;

    drive_cmd_e held_cmd;
    logic       held;   // A request is waiting
    logic       issue;

    // Translator idle and no pulse already on its way
    // A fresh request beats the held one
    assign issue = !cmd_ready && !pend_valid && (valid || held);

    always_ff @(posedge clk) begin
        if (rst) begin
            held       <= 1'b0;
            pend_valid <= 1'b0;
        end else begin
            pend_valid <= issue;
            if (issue) begin
                held <= 1'b0;
            end else if (valid) begin
                held <= 1'b1;  // Busy, keep the newest
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid) begin
            held_cmd <= command;  // Latest request always wins
        end
        if (issue) begin
            pend_cmd <= valid ? command : held_cmd;
        end
    end

endmodule

// File: rtl/drive_link_top.sv
module drive_link_top (
    input  logic                  clk,
    input  logic                  rst,
    input  drive_pkg::drive_cmd_e command,
    input  logic                  valid,
    output logic                  tx,
    output logic                  busy
);
    import drive_pkg::*;

    drive_cmd_e pend_cmd;
    logic       pend_valid;
    logic [7:0] ascii_out;
    logic       cmd_ready;
    logic       uart_ready;

    assign busy = cmd_ready;  // High while a line is being sent

    command_hold command_hold_inst (
        .clk        (clk),
        .rst        (rst),
        .command    (command),
        .valid      (valid),
        .cmd_ready  (cmd_ready),
        .pend_cmd   (pend_cmd),
        .pend_valid (pend_valid)
    );

    command_translator command_translator_inst (
        .clk        (clk),
        .rst        (rst),
        .command    (pend_cmd),
        .valid      (pend_valid),
        .uart_ready (uart_ready),
        .ascii_out  (ascii_out),
        .cmd_ready  (cmd_ready)
    );

    uart_tx uart_tx_inst (
        .clk        (clk),
        .rst        (rst),
        .data       (ascii_out),
        .data_valid (cmd_ready),
        .data_taken (uart_ready),
        .tx         (tx)
    );

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the drive link testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module drive_link_tb -f project.f \
    -o drive_link_sim || { echo "Build failed"; exit 1; }

./obj_dir/drive_link_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "PASS: all tests" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: tb/drive_link_checker.sv
module drive_link_checker (
    input logic       clk,
    input logic       rst,
    input logic [2:0] command,
    input logic       valid,
    input logic       tx,
    input logic       busy,
    input logic [2:0] pend_cmd,
    input logic       pend_valid,
    output logic      any_fail
);
    import drive_pkg::*;
    import uart_pkg::*;

    logic       rx_active;  // Inside a frame
    int         phase;      // Clocks into the current bit
    int         bit_idx;    // 0 start, 1..8 data, 9 stop
    logic [7:0] rx_byte;
    int         byte_idx;   // Position within the current line
    logic [2:0] issued_cmd;
    logic [2:0] line_cmd;   // Command of the line on the wire
    logic       cmd_seen;   // Issued command still waiting for its first frame
    logic [2:0] last_req;
    logic       req_open;   // Request not yet turned into a line
    logic       started;
    logic       mid_bit;
    logic       frame_start;
    logic       frame_end;
    logic [7:0] exp_byte;
    logic       fail_idle = 1'b0;
    logic       fail_start = 1'b0;
    logic       fail_stop = 1'b0;
    logic       fail_width = 1'b0;
    logic       fail_byte = 1'b0;
    logic       fail_busy = 1'b0;
    logic       fail_line = 1'b0;
    logic       fail_issue = 1'b0;
    logic       fail_pending = 1'b0;
    logic       fail_accept = 1'b0;

    // Reference lines, byte 0 first
    function automatic logic [7:0] expected_byte(input logic [2:0] cmd, input int idx);
        string line;
        case (cmd)
            FAST_LEFT:  line = "{\"T\":1,\"L\":-0.50,\"R\":00.50}\n";
            LEFT:       line = "{\"T\":1,\"L\":-0.25,\"R\":00.25}\n";
            STRAIGHT:   line = "{\"T\":1,\"L\":00.50,\"R\":00.50}\n";
            RIGHT:      line = "{\"T\":1,\"L\":00.25,\"R\":-0.25}\n";
            HARD_RIGHT: line = "{\"T\":1,\"L\":00.50,\"R\":-0.50}\n";
            default:    line = "{\"T\":0,\"L\":00.00,\"R\":00.00}\n";  // Stop, codes 6 and 7
        endcase
        return line[idx];
    endfunction

    assign mid_bit     = rx_active && (phase == CLKS_PER_BIT / 2);
    assign frame_start = !rx_active && !tx;
    assign frame_end   = mid_bit && (bit_idx == FRAME_BITS - 1);
    assign exp_byte    = expected_byte(line_cmd, byte_idx);
    assign any_fail    = fail_idle | fail_start | fail_stop | fail_width |
                         fail_byte | fail_busy | fail_line | fail_issue |
                         fail_pending | fail_accept;

    // Bit timing from the falling edge of the start bit
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_active <= 1'b0;
            phase     <= 0;
            bit_idx   <= 0;
        end else if (frame_start) begin
            rx_active <= 1'b1;
            phase     <= 1;
            bit_idx   <= 0;
        end else if (rx_active) begin
            if (phase == CLKS_PER_BIT - 1) begin
                phase <= 0;
                if (bit_idx == FRAME_BITS - 1) begin
                    rx_active <= 1'b0;
                end else begin
                    bit_idx <= bit_idx + 1;
                end
            end else begin
                phase <= phase + 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_idx <= 0;
            cmd_seen <= 1'b0;
            req_open <= 1'b0;
            started  <= 1'b0;
        end else begin
            if (valid) begin
                started  <= 1'b1;
                last_req <= command;
                req_open <= 1'b1;
            end else if (pend_valid) begin
                req_open <= 1'b0;
            end
            if (pend_valid) begin
                issued_cmd <= pend_cmd;
                cmd_seen   <= 1'b1;
            end else if (frame_start && byte_idx == 0) begin
                line_cmd <= issued_cmd;  // New line begins on the wire
                cmd_seen <= 1'b0;
            end
            if (mid_bit && bit_idx >= 1 && bit_idx <= FRAME_BITS - 2) begin
                rx_byte <= {tx, rx_byte[7:1]};  // LSB arrives first
            end
            if (frame_end) begin
                byte_idx <= (byte_idx == JSON_LEN - 1) ? 0 : byte_idx + 1;
            end
        end
    end

    a_idle: assert property (@(posedge clk) disable iff (rst) !started |-> tx && !busy)
        else begin
            fail_idle = 1'b1;
            $error("FAILED %0t: line or busy active before the first command", $time);
        end
    a_start: assert property (@(posedge clk) disable iff (rst) mid_bit && bit_idx == 0 |-> !tx)
        else begin
            fail_start = 1'b1;
            $error("FAILED %0t: start bit is not low", $time);
        end
    a_stop: assert property (@(posedge clk) disable iff (rst) frame_end |-> tx)
        else begin
            fail_stop = 1'b1;
            $error("FAILED %0t: stop bit is not high", $time);
        end
    a_width: assert property (@(posedge clk) disable iff (rst)
        rx_active && phase != 0 |-> $stable(tx))
        else begin
            fail_width = 1'b1;
            $error("FAILED %0t: tx changed inside a bit period", $time);
        end
    a_byte: assert property (@(posedge clk) disable iff (rst) frame_end |-> rx_byte == exp_byte)
        else begin
            fail_byte = 1'b1;
            $error("FAILED %0t: byte %0d is %h, expected %h", $time, byte_idx, rx_byte,
                   exp_byte);
        end
    a_busy: assert property (@(posedge clk) disable iff (rst)
        frame_end && byte_idx < JSON_LEN - 1 |-> busy)
        else begin
            fail_busy = 1'b1;
            $error("FAILED %0t: busy low before the line was fully taken", $time);
        end
    a_line: assert property (@(posedge clk) disable iff (rst)
        frame_start && byte_idx == 0 |-> cmd_seen)
        else begin
            fail_line = 1'b1;
            $error("FAILED %0t: line started without an issued command", $time);
        end
    a_issue: assert property (@(posedge clk) disable iff (rst)
        pend_valid |-> req_open && pend_cmd == last_req &&
                       (byte_idx == 0 || byte_idx == JSON_LEN - 1))
        else begin
            fail_issue = 1'b1;
            $error("FAILED %0t: issued command %0d is not the latest open request", $time,
                   pend_cmd);
        end
    // An open request must go out as soon as the translator is free
    a_pending: assert property (@(posedge clk) disable iff (rst)
        req_open && !busy && !pend_valid |=> pend_valid)
        else begin
            fail_pending = 1'b1;
            $error("FAILED %0t: open request %0d was not issued", $time, last_req);
        end
    a_accept: assert property (@(posedge clk) disable iff (rst) pend_valid |=> busy)
        else begin
            fail_accept = 1'b1;
            $error("FAILED %0t: issued command did not start a line", $time);
        end

endmodule

// File: tb/drive_link_tb.sv
module drive_link_tb;
    import drive_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int FRAME_CYCLES = uart_pkg::FRAME_BITS * uart_pkg::CLKS_PER_BIT;
    localparam int QUIET_CYCLES = FRAME_CYCLES + uart_pkg::CLKS_PER_BIT;  // Longer than any frame
    localparam int LINE_TIMEOUT = 2 * JSON_LEN * FRAME_CYCLES;
    localparam int NUM_RANDOM   = 20;

    logic       clk;
    logic       rst;
    drive_cmd_e command;
    logic       valid;
    logic       tx;
    logic       busy;
    logic       checker_fail;

    drive_link_top drive_link_top_inst (
        .clk     (clk),
        .rst     (rst),
        .command (command),
        .valid   (valid),
        .tx      (tx),
        .busy    (busy)
    );

    bind drive_link_top drive_link_checker drive_link_checker_inst (
        .clk        (clk),
        .rst        (rst),
        .command    (command),
        .valid      (valid),
        .tx         (tx),
        .busy       (busy),
        .pend_cmd   (pend_cmd),
        .pend_valid (pend_valid),
        .any_fail   ()
    );

    assign checker_fail = drive_link_top_inst.drive_link_checker_inst.any_fail;

    always #20 clk = ~clk;

    // Stop at the first failed assertion
    always @(negedge clk) begin
        if (checker_fail) begin
            $display("FAIL: see errors above");
            $fatal(1, "Assertion failure in the line checker");
        end
    end

    task automatic timeout_abort(input string what);
        $display("Timeout while waiting for %s", what);
        $display("FAIL: see errors above");
        $fatal(1, "Testbench timeout");
    endtask

    // One-cycle request strobe
    task automatic send_command(input drive_cmd_e cmd);
        @(posedge clk);
        command <= cmd;
        valid   <= 1'b1;
        @(posedge clk);
        valid <= 1'b0;
    endtask

    task automatic await_busy(input logic level, input int limit);
        int cycles;
        cycles = 0;
        while (busy !== level && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (busy !== level) begin
            timeout_abort("busy to change level");
        end
    endtask

    // Busy low and tx high for longer than a frame
    task automatic settle_idle(input int limit);
        int cycles;
        int quiet;
        cycles = 0;
        quiet  = 0;
        while (quiet < QUIET_CYCLES && cycles < limit) begin
            @(negedge clk);
            cycles++;
            if (busy || !tx) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
        if (quiet < QUIET_CYCLES) begin
            timeout_abort("the link to go idle");
        end
    endtask

    initial begin
        int         seed;
        int         gap;
        logic [2:0] code;
        seed    = int'($urandom(86));
        clk     = 1'b0;
        rst     = 1'b1;
        valid   = 1'b0;
        command = drive_cmd_e'(3'd0);
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        repeat (20) @(posedge clk);  // Quiet line before any command

        // Every code once, named ones and the two spare codes
        for (int c = 0; c < 8; c++) begin
            send_command(drive_cmd_e'(3'(c)));
            await_busy(1'b1, 20);
            settle_idle(LINE_TIMEOUT);
        end

        // Two requests during one line, the later one must follow
        send_command(STRAIGHT);
        await_busy(1'b1, 20);
        repeat (100) @(posedge clk);
        send_command(LEFT);
        repeat (200) @(posedge clk);
        send_command(HARD_RIGHT);
        settle_idle(3 * LINE_TIMEOUT);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            code = 3'($urandom % 8);
            gap  = int'($urandom % 1500);
            send_command(drive_cmd_e'(code));
            repeat (gap) @(posedge clk);
        end
        settle_idle(3 * LINE_TIMEOUT);

        if (checker_fail) begin
            $display("FAIL: see errors above");
            $fatal(1, "Assertion failure in the line checker");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// File: uart_tx/uart_tx.sv
module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] data,
    input  logic       data_valid,
    output logic       data_taken,
    output logic       tx
);
    import uart_pkg::*;

    uart_state_e          state;
    logic [CLK_CNT_W-1:0] clk_cnt;   // Clocks into the current bit
    logic [BIT_CNT_W-1:0] bit_cnt;   // Data bit being sent
    logic [7:0]           shift_q;
    logic                 bit_end;

    assign bit_end = (clk_cnt == LAST_CLK);

    // Load happens in the same cycle as the pulse
    assign data_taken = (state == IDLE) && data_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    clk_cnt <= '0;
                    if (data_valid) begin
                        state <= START;
                    end
                end
                START: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        if (bit_cnt == LAST_BIT) begin
                            state <= STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                STOP: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        state   <= IDLE;  // Next take one cycle later
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Shift register, LSB goes out first
    always_ff @(posedge clk) begin
        if (data_taken) begin
            shift_q <= data;
        end else if (state == DATA && bit_end) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    // Line level per state
    always_comb begin
        case (state)
            START:   tx = 1'b0;
            DATA:    tx = shift_q[0];
            default: tx = 1'b1;  // Idle and stop bit
        endcase
    end

endmodule
